/* files.f */
source/mcu_link_pkg.sv
source/frame_receiver.sv
source/command_executor.sv
source/word_store.sv
source/reply_sender.sv
source/mcu_link_top.sv
sim/mcu_link_tb.sv

/* Makefile */
TOP := mcu_link_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/100ps --top-module $(TOP) -f files.f -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

/* sim/mcu_link_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module mcu_link_tb;

  localparam int STORE_ADDR_W = 6;           // DUT default
  localparam int SER_HALF     = 8;           // sys_clk per ser_clk half period
  localparam int SER_PERIOD   = 4 * 2 * SER_HALF;  // ns
  localparam int NUM_FRAMES   = 93;          // all frames sent by the tests below
  localparam int WATCHDOG_NS  = NUM_FRAMES * 80 * SER_PERIOD + 200;

  // command bytes of the link
  localparam logic [7:0] OP_SET_DATA_LO = 8'h10;
  localparam logic [7:0] OP_SET_DATA_HI = 8'h11;
  localparam logic [7:0] OP_SET_ADDR_LO = 8'h12;
  localparam logic [7:0] OP_SET_ADDR_HI = 8'h13;
  localparam logic [7:0] OP_ECHO        = 8'h30;
  localparam logic [7:0] OP_WRITE_WORD  = 8'hA0;
  localparam logic [7:0] OP_READ_WORD   = 8'hA1;
  localparam logic [7:0] ECHO_TAG       = 8'h12;  // first reply byte of an echo

  logic        sys_clk;
  logic        sys_rst_n;
  logic        ser_clk;
  logic        ser_din;
  logic        ser_dout;
  logic        busy;
  logic [31:0] lfsr_q;

  mcu_link_top UUT (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .ser_clk   (ser_clk),
    .ser_din   (ser_din),
    .ser_dout  (ser_dout),
    .busy      (busy)
  );

  initial begin
    sys_clk = 1'b0;
    forever #2 sys_clk = ~sys_clk;  // 4 ns period
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the tests finished");
    stop_run();
  end

  task automatic stop_run();
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_equal(input logic [15:0] got, input logic [15:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("Mismatch at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  // galois form, taps 32,22,2,1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[14:0], lfsr_q[0]};  // one step per bit
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  task automatic half_period();
    repeat (SER_HALF) @(negedge sys_clk);
  endtask

  // one full ser_clk period, value seen just before the falling edge
  task automatic clock_ser_period(output logic sampled);
    half_period();
    ser_clk = 1'b1;
    half_period();
    sampled = ser_dout;
    ser_clk = 1'b0;
  endtask

  task automatic send_frame(input logic [7:0] cmd, input logic [7:0] dat);
    logic [16:0] bits;
    bits = {dat, cmd, 1'b1};  // start bit goes first, lsb first after it
    for (int i = 0; i < 17; i++) begin
      ser_din = bits[i];      // ser_clk is low here
      half_period();
      ser_clk = 1'b1;
      half_period();
      ser_clk = 1'b0;
    end
    ser_din = 1'b0;           // idle line, no false start bit
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (busy && n < 200) begin
      @(negedge sys_clk);
      n++;
    end
    if (busy) begin
      $display("busy stayed high for 200 cycles after a command");
      stop_run();
    end
  endtask

  task automatic get_reply(output logic [15:0] word);
    logic b;
    int   periods;
    b       = 1'b0;
    periods = 0;
    while (!b && periods < 40) begin  // hunt for start bit
      clock_ser_period(b);
      periods++;
    end
    if (!b) begin
      $display("No start bit on ser_dout within 40 ser_clk periods");
      stop_run();
    end
    for (int i = 0; i < 16; i++) begin
      clock_ser_period(b);
      word[i] = b;            // lo byte first
    end
    clock_ser_period(b);
    check_equal({15'd0, b}, 16'h0000, "stop bit");
  endtask

  task automatic expect_no_reply();
    logic b;
    for (int i = 0; i < 40; i++) begin
      clock_ser_period(b);
      check_equal({15'd0, b}, 16'h0000, "ser_dout without a pending reply");
    end
  endtask

  task automatic set_addr(input logic [15:0] addr);
    send_frame(OP_SET_ADDR_LO, addr[7:0]);
    wait_idle();
    send_frame(OP_SET_ADDR_HI, addr[15:8]);
    wait_idle();
  endtask

  task automatic write_word(input logic [15:0] addr, input logic [15:0] data);
    send_frame(OP_SET_DATA_LO, data[7:0]);
    wait_idle();
    send_frame(OP_SET_DATA_HI, data[15:8]);
    wait_idle();
    set_addr(addr);
    send_frame(OP_WRITE_WORD, 8'h00);
    wait_idle();
  endtask

  task automatic read_word(input logic [15:0] addr, output logic [15:0] data);
    set_addr(addr);
    send_frame(OP_READ_WORD, 8'h00);
    get_reply(data);
    wait_idle();              // busy drops once the reply is out
  endtask

  task automatic reset_state_is_idle();
    check_equal({14'd0, busy, ser_dout}, 16'h0000, "busy and ser_dout after reset");
  endtask

  task automatic echo_returns_tag();
    logic [15:0] d;
    logic [15:0] got;
    for (int i = 0; i < 3; i++) begin
      rand_bits(8, d);
      send_frame(OP_ECHO, d[7:0]);
      get_reply(got);
      wait_idle();
      check_equal(got, {d[7:0], ECHO_TAG}, "echo reply");
    end
  endtask

  task automatic words_read_back();
    logic [15:0] addr;
    logic [15:0] data;
    logic [15:0] got;
    for (int i = 0; i < 8; i++) begin
      rand_bits(16, addr);
      rand_bits(16, data);
      write_word(addr, data);
      read_word(addr, got);
      check_equal(got, data, "read after write");
    end
  endtask

  task automatic upper_address_aliases();
    logic [15:0] base;
    logic [15:0] hi_bits;
    logic [15:0] data;
    logic [15:0] got;
    rand_bits(STORE_ADDR_W, base);
    rand_bits(16 - STORE_ADDR_W, hi_bits);
    rand_bits(16, data);
    hi_bits = hi_bits | 16'h0001;  // at least one upper bit differs
    write_word(base, data);
    read_word(base ^ (hi_bits << STORE_ADDR_W), got);
    check_equal(got, data, "read through aliased address");
  endtask

  task automatic unknown_opcode_ignored();
    logic [15:0] got;
    write_word(16'h0005, 16'h5AC3);
    // new data word held but not written, address still 5
    send_frame(OP_SET_DATA_LO, 8'h96);
    wait_idle();
    send_frame(OP_SET_DATA_HI, 8'h3C);
    wait_idle();
    send_frame(8'h60, 8'hFF);     // dropped fifo command
    expect_no_reply();
    wait_idle();
    send_frame(8'hB0, 8'h0F);     // dropped dma command
    expect_no_reply();
    wait_idle();
    read_word(16'h0005, got);
    check_equal(got, 16'h5AC3, "stored word after unknown opcodes");
    // write with no fresh set data, last data set still there
    set_addr(16'h0009);
    send_frame(OP_WRITE_WORD, 8'h00);
    wait_idle();
    read_word(16'h0009, got);
    check_equal(got, 16'h3C96, "data register after unknown opcodes");
  endtask

  initial begin
    sys_rst_n = 1'b0;
    ser_clk   = 1'b0;
    ser_din   = 1'b0;
    lfsr_q    = 32'hea8d86db;
    repeat (16) @(posedge sys_clk);
    @(negedge sys_clk);
    sys_rst_n = 1'b1;
    repeat (4) @(negedge sys_clk);

    reset_state_is_idle();
    echo_returns_tag();
    words_read_back();
    upper_address_aliases();
    unknown_opcode_ignored();

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* source/mcu_link_top.sv */
`timescale 1ns/100ps
`default_nettype none

module mcu_link_top #(
  parameter int STORE_ADDR_W = 6  // store holds 2**STORE_ADDR_W words
) (
  input  logic sys_clk,
  input  logic sys_rst_n,
  input  logic ser_clk,
  input  logic ser_din,
  output logic ser_dout,
  output logic busy
);

  import mcu_link_pkg::*;

  // receiver to executor
  logic  frame_req;
  logic  frame_ack;
  byte_t frame_cmd;
  byte_t frame_dat;

  // executor to store
  logic                    store_req;
  logic                    store_write;
  logic                    store_ack;
  logic [STORE_ADDR_W-1:0] store_addr;
  word_t                   store_wdata;
  word_t                   store_rdata;

  // executor to sender
  logic  reply_req;
  logic  reply_ack;
  byte_t reply_lo;
  byte_t reply_hi;

  frame_receiver u_frame_receiver (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .ser_clk   (ser_clk),
    .ser_din   (ser_din),
    .frame_req (frame_req),
    .frame_cmd (frame_cmd),
    .frame_dat (frame_dat),
    .frame_ack (frame_ack)
  );

  command_executor #(
    .STORE_ADDR_W (STORE_ADDR_W)
  ) u_command_executor (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .frame_req   (frame_req),
    .frame_cmd   (frame_cmd),
    .frame_dat   (frame_dat),
    .frame_ack   (frame_ack),
    .store_req   (store_req),
    .store_write (store_write),
    .store_addr  (store_addr),
    .store_wdata (store_wdata),
    .store_rdata (store_rdata),
    .store_ack   (store_ack),
    .reply_req   (reply_req),
    .reply_lo    (reply_lo),
    .reply_hi    (reply_hi),
    .reply_ack   (reply_ack),
    .busy        (busy)
  );

  word_store #(
    .STORE_ADDR_W (STORE_ADDR_W)
  ) u_word_store (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .store_req   (store_req),
    .store_write (store_write),
    .store_addr  (store_addr),
    .store_wdata (store_wdata),
    .store_rdata (store_rdata),
    .store_ack   (store_ack)
  );

  // shares ser_clk with the receiver
  reply_sender u_reply_sender (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .ser_clk   (ser_clk),
    .reply_req (reply_req),
    .reply_lo  (reply_lo),
    .reply_hi  (reply_hi),
    .reply_ack (reply_ack),
    .ser_dout  (ser_dout)
  );

endmodule

`default_nettype wire

/* source/reply_sender.sv */
`timescale 1ns/100ps
`default_nettype none

module reply_sender (
  input  logic                sys_clk,
  input  logic                sys_rst_n,
  input  logic                ser_clk,   // host bit clock
  input  logic                reply_req,
  input  mcu_link_pkg::byte_t reply_lo,
  input  mcu_link_pkg::byte_t reply_hi,
  output logic                reply_ack,
  output logic                ser_dout   // device to host
);

  import mcu_link_pkg::*;

  localparam int LAST_STEP = FRAME_BITS + 1;  // stop bit
  localparam int STEP_W    = $clog2(LAST_STEP + 1);

  logic [2:0]        clk_sync;
  logic              clk_rise;
  logic              sending;
  logic              load;      // take a new reply word
  logic [STEP_W-1:0] step;      // 0 start, 1..16 data, last is stop
  word_t             shift_q;

  assign clk_rise = clk_sync[1] & ~clk_sync[2];
  assign load     = !sending && reply_req && !reply_ack;

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      clk_sync  <= '0;
      sending   <= 1'b0;
      step      <= '0;
      reply_ack <= 1'b0;
      ser_dout  <= 1'b0;
    end else begin
      clk_sync <= {clk_sync[1:0], ser_clk};

      if (reply_ack && !reply_req) begin
        reply_ack <= 1'b0;
      end

      if (load) begin
        sending <= 1'b1;
        step    <= '0;
      end else if (sending && clk_rise) begin
        step <= step + 1'b1;
        if (step == '0) begin
          ser_dout <= 1'b1;  // start bit
        end else if (step == STEP_W'(LAST_STEP)) begin
          ser_dout  <= 1'b0;  // stop bit, line back to idle level
          reply_ack <= 1'b1;
          sending   <= 1'b0;
        end else begin
          ser_dout <= shift_q[0];
        end
      end
    end
  end

  // lo byte shifts out before hi byte
  always_ff @(posedge sys_clk) begin
    if (load) begin
      shift_q <= {reply_hi, reply_lo};
    end else if (sending && clk_rise && step != '0) begin
      shift_q <= shift_q >> 1;
    end
  end

endmodule

`default_nettype wire

/* source/word_store.sv */
`timescale 1ns/100ps
`default_nettype none

module word_store #(
  parameter int STORE_ADDR_W = 6
) (
  input  logic                    sys_clk,
  input  logic                    sys_rst_n,
  input  logic                    store_req,
  input  logic                    store_write,
  input  logic [STORE_ADDR_W-1:0] store_addr,
  input  mcu_link_pkg::word_t     store_wdata,
  output mcu_link_pkg::word_t     store_rdata,  // valid while store_ack
  output logic                    store_ack
);

  import mcu_link_pkg::*;

  localparam int DEPTH = 2 ** STORE_ADDR_W;

  word_t mem [DEPTH];
  logic  op_en;  // first cycle of a request

  // one access per handshake
  assign op_en = store_req && !store_ack;

  // ack follows req by one cycle, both edges
  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      store_ack <= 1'b0;
    end else begin
      store_ack <= store_req;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (op_en) begin
      if (store_write) begin
        mem[store_addr] <= store_wdata;
      end
      store_rdata <= mem[store_addr];  // old word on a write
    end
  end

endmodule

`default_nettype wire

/* source/command_executor.sv */
`timescale 1ns/100ps
`default_nettype none

module command_executor #(
  parameter int STORE_ADDR_W = 6
) (
  input  logic                    sys_clk,
  input  logic                    sys_rst_n,
  input  logic                    frame_req,
  input  mcu_link_pkg::byte_t     frame_cmd,
  input  mcu_link_pkg::byte_t     frame_dat,
  output logic                    frame_ack,
  output logic                    store_req,
  output logic                    store_write,  // 1 write, 0 read
  output logic [STORE_ADDR_W-1:0] store_addr,
  output mcu_link_pkg::word_t     store_wdata,
  input  mcu_link_pkg::word_t     store_rdata,
  input  logic                    store_ack,
  output logic                    reply_req,
  output mcu_link_pkg::byte_t     reply_lo,     // sent first
  output mcu_link_pkg::byte_t     reply_hi,
  input  logic                    reply_ack,
  output logic                    busy
);

  import mcu_link_pkg::*;

  exec_state_e state;
  cmd_op_e     op;        // decoded command byte
  word_t       data_q;    // write word
  word_t       addr_q;    // word address, upper bits may alias
  logic        accept;    // take frame this cycle
  logic        rd_done;   // read data on store_rdata

  assign op = cmd_op_e'(frame_cmd);

  // previous reply must be fully closed before a new frame
  assign accept  = (state == IDLE) && frame_req && !frame_ack && !reply_ack;
  assign rd_done = (state == STORE) && store_req && store_ack && !store_write;

  // registers stay put for the whole store handshake
  assign store_addr  = addr_q[STORE_ADDR_W-1:0];
  assign store_wdata = data_q;

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state       <= IDLE;
      frame_ack   <= 1'b0;
      store_req   <= 1'b0;
      store_write <= 1'b0;
      reply_req   <= 1'b0;
      busy        <= 1'b0;
      data_q      <= '0;
      addr_q      <= '0;
    end else begin
      // frame handshake closes on its own so the next frame can shift in
      if (frame_ack && !frame_req) begin
        frame_ack <= 1'b0;
      end

      case (state)
        IDLE: begin
          if (accept) begin
            frame_ack <= 1'b1;
            busy      <= 1'b1;
            state     <= FINISH;  // register ops and unknown codes
            case (op)
              OP_SET_DATA_LO: data_q[7:0]  <= frame_dat;
              OP_SET_DATA_HI: data_q[15:8] <= frame_dat;
              OP_SET_ADDR_LO: addr_q[7:0]  <= frame_dat;
              OP_SET_ADDR_HI: addr_q[15:8] <= frame_dat;
              OP_ECHO: begin
                reply_req <= 1'b1;  // bytes latched below
                state     <= REPLY;
              end
              OP_WRITE_WORD: begin
                store_req   <= 1'b1;
                store_write <= 1'b1;
                state       <= STORE;
              end
              OP_READ_WORD: begin
                store_req   <= 1'b1;
                store_write <= 1'b0;
                state       <= STORE;
              end
              default: ;  // no effect, no reply
            endcase
          end
        end

        STORE: begin
          if (store_req && store_ack) begin
            store_req <= 1'b0;
          end else if (!store_req && !store_ack) begin
            // store handshake closed
            if (store_write) begin
              state <= FINISH;
            end else begin
              reply_req <= 1'b1;
              state     <= REPLY;
            end
          end
        end

        REPLY: begin
          if (reply_ack) begin
            reply_req <= 1'b0;  // stop bit is out
            state     <= FINISH;
          end
        end

        FINISH: begin
          busy  <= 1'b0;
          state <= IDLE;
        end

        default: state <= IDLE;
      endcase
    end
  end

  // reply bytes, low byte goes out first
  always_ff @(posedge sys_clk) begin
    if (accept && op == OP_ECHO) begin
      reply_lo <= ECHO_TAG;
      reply_hi <= frame_dat;
    end else if (rd_done) begin
      reply_lo <= store_rdata[7:0];
      reply_hi <= store_rdata[15:8];
    end
  end

endmodule

`default_nettype wire

/* source/frame_receiver.sv */
`timescale 1ns/100ps
`default_nettype none

module frame_receiver (
  input  logic                sys_clk,
  input  logic                sys_rst_n,
  input  logic                ser_clk,    // host bit clock
  input  logic                ser_din,    // host to device
  output logic                frame_req,
  output mcu_link_pkg::byte_t frame_cmd,
  output mcu_link_pkg::byte_t frame_dat,
  input  logic                frame_ack
);

  import mcu_link_pkg::*;

  localparam int CNT_W = $clog2(FRAME_BITS + 1);

  logic [2:0]            clk_sync;   // two sync stages plus edge history
  logic [1:0]            din_sync;
  logic                  clk_rise;   // synchronized rising edge of ser_clk
  logic                  din_bit;    // sampled line value
  logic                  listen;     // no frame held
  logic [CNT_W-1:0]      bit_cnt;    // 0 waits for start bit
  logic [FRAME_BITS-1:0] shift_q;    // cmd in low byte, data in high byte

  assign clk_rise = clk_sync[1] & ~clk_sync[2];
  assign din_bit  = din_sync[1];
  assign listen   = !frame_req && !frame_ack;

  // first bit in ends up at bit 0
  assign frame_cmd = shift_q[7:0];
  assign frame_dat = shift_q[15:8];

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      clk_sync  <= '0;
      din_sync  <= '0;
      bit_cnt   <= '0;
      frame_req <= 1'b0;
    end else begin
      clk_sync <= {clk_sync[1:0], ser_clk};
      din_sync <= {din_sync[0], ser_din};

      if (frame_req && frame_ack) begin
        frame_req <= 1'b0;  // executor has the frame
      end

      if (clk_rise && listen) begin
        if (bit_cnt == '0) begin
          if (din_bit) begin
            bit_cnt <= CNT_W'(1);  // start bit
          end
        end else if (bit_cnt == CNT_W'(FRAME_BITS)) begin
          bit_cnt   <= '0;
          frame_req <= 1'b1;  // last data bit, offer frame
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

  // payload shift, lsb first
  always_ff @(posedge sys_clk) begin
    if (clk_rise && listen && bit_cnt != '0) begin
      shift_q <= {din_bit, shift_q[FRAME_BITS-1:1]};
    end
  end

endmodule

`default_nettype wire

/* source/mcu_link_pkg.sv */
`default_nettype none

package mcu_link_pkg;

  typedef logic [7:0]  byte_t;  // one byte of a frame or reply
  typedef logic [15:0] word_t;  // one stored word

  // command byte values seen on the link
  typedef enum byte_t {
    OP_SET_DATA_LO = 8'h10,  // write word, low byte
    OP_SET_DATA_HI = 8'h11,  // write word, high byte
    OP_SET_ADDR_LO = 8'h12,
    OP_SET_ADDR_HI = 8'h13,
    OP_ECHO        = 8'h30,  // link test
    OP_WRITE_WORD  = 8'hA0,
    OP_READ_WORD   = 8'hA1
  } cmd_op_e;

  // executor sequencing
  typedef enum logic [1:0] {
    IDLE,    // waiting for a frame
    STORE,   // store handshake open
    REPLY,   // reply handshake open
    FINISH   // drop busy
  } exec_state_e;

  // payload bits after the start bit, command then data
  localparam int FRAME_BITS = 16;

  // first reply byte of an echo
  localparam byte_t ECHO_TAG = 8'h12;

endpackage

`default_nettype wire
